//--- hw/chip8_isa_pkg.sv
//**********************************************************
// CHIP-8 instruction fields, opcode classes and ALU codes
// Dropped opcode classes all decode to OP_OTHER
//**********************************************************
`default_nettype none

package chip8_isa_pkg;

	// Field widths
	localparam int INSTR_W = 16;
	localparam int DATA_W = 8;
	localparam int ADDR_W = 12;
	localparam int REG_IDX_W = 4;

	typedef logic [DATA_W-1:0] byte_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Flag register
	localparam reg_idx_t VF_IDX = 4'hF;

	// Bytes per hex font glyph
	localparam byte_t FONT_STRIDE = 8'd5;

	// Top nibble classes that the core executes
	typedef enum logic [3:0] {
		OP_JP,
		OP_SE_IMM,
		OP_SNE_IMM,
		OP_SE_REG,
		OP_LD_IMM,
		OP_ADD_IMM,
		OP_ARITH,
		OP_SNE_REG,
		OP_LD_I,
		OP_JP_V0,
		OP_MISC_F,
		OP_OTHER
	} opclass_e;

	// NOP passes operand b through
	typedef enum logic [2:0] {
		ALU_NOP,
		ALU_OR,
		ALU_AND,
		ALU_XOR,
		ALU_ADD,
		ALU_SUB,
		ALU_SHR,
		ALU_SHL
	} alu_op_e;

endpackage

`default_nettype wire

//--- hw/chip8_uarch_pkg.sv
//**********************************************************
// Sequencer states and PC update sources of the core
// Stage counter sized for a 16-register dump
//**********************************************************
`default_nettype none

package chip8_uarch_pkg;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_EXEC,
		SEQ_DONE
	} seq_state_e;

	// NEXT is PC+2, SKIP is PC+4
	typedef enum logic [1:0] {
		PC_NEXT,
		PC_SKIP,
		PC_JUMP
	} pc_src_e;

	typedef logic [4:0] stage_t;

	// Fx55 with x = F runs stages 0 to 15
	localparam stage_t STAGE_MAX = 5'd15;

endpackage

`default_nettype wire

//--- hw/chip8_regs_if.sv
//**********************************************************
// Register file, I and PC access between exec and state
// Reads are combinational, writes land on the clock edge
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

interface chip8_regs_if import chip8_isa_pkg::*, chip8_uarch_pkg::*; ();

	// Two V register read ports
	reg_idx_t rd_idx1, rd_idx2;
	byte_t rd_data1, rd_data2;

	// Two V register write ports, port 2 has priority
	logic we1, we2;
	reg_idx_t wr_idx1, wr_idx2;
	byte_t wr_data1, wr_data2;

	// Index register
	logic i_we;
	logic [15:0] i_wdata, i_rdata;

	// Program counter update, pc_upd is a one-cycle strobe
	logic pc_upd;
	pc_src_e pc_src;
	addr_t pc_target, pc_rdata;

	modport master (
		output rd_idx1, rd_idx2, we1, wr_idx1, wr_data1, we2, wr_idx2, wr_data2,
		output i_we, i_wdata, pc_upd, pc_src, pc_target,
		input rd_data1, rd_data2, i_rdata, pc_rdata
	);

	modport slave (
		input rd_idx1, rd_idx2, we1, wr_idx1, wr_data1, we2, wr_idx2, wr_data2,
		input i_we, i_wdata, pc_upd, pc_src, pc_target,
		output rd_data1, rd_data2, i_rdata, pc_rdata
	);

endinterface

`default_nettype wire

//--- hw/chip8_alu.sv
//**********************************************************
// Byte ALU with flag, ADD also serves 16-bit address sums
// Byte ops expect zero in the upper bits of a and b
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module chip8_alu import chip8_isa_pkg::*; (
	input wire alu_op_e op,
	input wire logic [15:0] a,
	input wire logic [15:0] b,
	output logic [15:0] result,
	output logic flag
);

	// Carry out of the low byte
	logic [8:0] sum8;

	assign sum8 = {1'b0, a[7:0]} + {1'b0, b[7:0]};

	always_comb begin
		result = '0;
		flag = 1'b0;
		case (op)
			ALU_NOP: result = b;
			ALU_OR: result = a | b;
			ALU_AND: result = a & b;
			ALU_XOR: result = a ^ b;
			ALU_ADD: begin
				// Full 16-bit sum, flag only means something for bytes
				result = a + b;
				flag = sum8[8];
			end
			ALU_SUB: begin
				// Flag set when no borrow
				result = a - b;
				flag = (a[7:0] >= b[7:0]);
			end
			ALU_SHR: begin
				result = {9'h0, a[7:1]};
				flag = a[0];
			end
			ALU_SHL: begin
				result = {8'h0, a[6:0], 1'b0};
				flag = a[7];
			end
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/chip8_bcd.sv
//**********************************************************
// Byte to three decimal digits by shift-and-add-three
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module chip8_bcd import chip8_isa_pkg::*; (
	input wire byte_t value,
	output byte_t hundreds,
	output byte_t tens,
	output byte_t ones
);

	// Digits in [19:8], binary value shifts out of [7:0]
	logic [19:0] work;

	always_comb begin
		work = {12'h000, value};
		for (int i = 0; i < 8; i++) begin
			// Correct any digit that would pass 9 after the shift
			if (work[11:8] > 4'd4)
				work[11:8] = work[11:8] + 4'd3;
			if (work[15:12] > 4'd4)
				work[15:12] = work[15:12] + 4'd3;
			if (work[19:16] > 4'd4)
				work[19:16] = work[19:16] + 4'd3;
			work = work << 1;
		end
	end

	assign hundreds = {4'h0, work[19:16]};
	assign tens = {4'h0, work[15:12]};
	assign ones = {4'h0, work[11:8]};

endmodule

`default_nettype wire

//--- hw/chip8_state_regs.sv
//**********************************************************
// V0..VF, I and PC, all cleared by reset except PC
// Write port 2 beats port 1 on the same index
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module chip8_state_regs import chip8_isa_pkg::*, chip8_uarch_pkg::*; #(
	parameter addr_t RESET_PC = 12'h200
) (
	input wire logic cpu_clk,
	input wire logic arst_n,
	chip8_regs_if.slave regs,
	output addr_t pc
);

	byte_t v_q [16];
	logic [15:0] i_q;
	addr_t pc_q;

	always_ff @(posedge cpu_clk or negedge arst_n) begin
		if (!arst_n) begin
			v_q <= '{default: '0};
			i_q <= '0;
			pc_q <= RESET_PC;
		end else begin
			if (regs.we1)
				v_q[regs.wr_idx1] <= regs.wr_data1;
			// Second so the VF flag overrides a result aimed at VF
			if (regs.we2)
				v_q[regs.wr_idx2] <= regs.wr_data2;
			if (regs.i_we)
				i_q <= regs.i_wdata;
			if (regs.pc_upd) begin
				case (regs.pc_src)
					PC_SKIP: pc_q <= pc_q + 12'd4;
					PC_JUMP: pc_q <= regs.pc_target;
					default: pc_q <= pc_q + 12'd2;
				endcase
			end
		end
	end

	// Asynchronous reads
	assign regs.rd_data1 = v_q[regs.rd_idx1];
	assign regs.rd_data2 = v_q[regs.rd_idx2];
	assign regs.i_rdata = i_q;
	assign regs.pc_rdata = pc_q;
	assign pc = pc_q;

	// Instructions are two bytes, so every PC value lands on an even address
	a_pc_even: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		!pc[0]);

endmodule

`default_nettype wire

//--- hw/chip8_sequencer.sv
//**********************************************************
// Four-phase instr_req/instr_ack framing of each instruction
// Ack holds in DONE until the request drops
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module chip8_sequencer import chip8_uarch_pkg::*; (
	input wire logic cpu_clk,
	input wire logic arst_n,
	input wire logic instr_req,
	input wire logic last_stage,
	output logic exec_active,
	output stage_t stage,
	output logic instr_ack
);

	seq_state_e state_q;
	stage_t stage_q;

	always_ff @(posedge cpu_clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= SEQ_IDLE;
			stage_q <= '0;
		end else begin
			case (state_q)
				SEQ_IDLE: begin
					// Exec latches the instruction on this same edge
					stage_q <= '0;
					if (instr_req)
						state_q <= SEQ_EXEC;
				end
				SEQ_EXEC: begin
					if (last_stage) begin
						state_q <= SEQ_DONE;
						stage_q <= '0;
					end else begin
						stage_q <= stage_q + 5'd1;
					end
				end
				SEQ_DONE: begin
					// Back-pressure, wait for the request to fall
					if (!instr_req)
						state_q <= SEQ_IDLE;
				end
				default: state_q <= SEQ_IDLE;
			endcase
		end
	end

	assign exec_active = (state_q == SEQ_EXEC);
	assign instr_ack = (state_q == SEQ_DONE);
	assign stage = stage_q;

	// Ack only answers a request that was still up on the edge that raised it
	a_ack_needs_req: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		$rose(instr_ack) |-> $past(instr_req));

	// Exec must report last_stage before the counter runs past 15
	a_stage_max: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		exec_active |-> stage <= STAGE_MAX);

endmodule

`default_nettype wire

//--- hw/chip8_exec.sv
//**********************************************************
// Per-stage decode of the latched instruction
// Register, I and PC writes commit only in the last stage
// Fx33 takes 3 stages, Fx55 takes x+1, all others take 1
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module chip8_exec import chip8_isa_pkg::*, chip8_uarch_pkg::*; (
	input wire logic cpu_clk,
	input wire logic arst_n,
	input wire logic [INSTR_W-1:0] instruction,
	input wire logic exec_active,
	input wire stage_t stage,
	output logic last_stage,
	chip8_regs_if.master regs,
	output logic mem_we,
	output addr_t mem_addr,
	output byte_t mem_wdata
);

	logic [INSTR_W-1:0] instr_q;
	opclass_e cls;
	reg_idx_t x_idx, y_idx, n_low;
	byte_t kk;
	addr_t nnn;
	alu_op_e alu_op;
	logic [15:0] alu_a, alu_b, alu_result;
	logic alu_flag, commit, mem_wr;
	byte_t bcd_h, bcd_t, bcd_o;

	// Capture while idle, hold through all stages
	always_ff @(posedge cpu_clk)
		if (!exec_active)
			instr_q <= instruction;

	assign x_idx = instr_q[11:8];
	assign y_idx = instr_q[7:4];
	assign n_low = instr_q[3:0];
	assign kk = instr_q[7:0];
	assign nnn = instr_q[11:0];
	assign commit = exec_active && last_stage;

	always_comb begin
		case (instr_q[15:12])
			4'h1: cls = OP_JP;
			4'h3: cls = OP_SE_IMM;
			4'h4: cls = OP_SNE_IMM;
			4'h5: cls = OP_SE_REG;
			4'h6: cls = OP_LD_IMM;
			4'h7: cls = OP_ADD_IMM;
			4'h8: cls = OP_ARITH;
			4'h9: cls = OP_SNE_REG;
			4'hA: cls = OP_LD_I;
			4'hB: cls = OP_JP_V0;
			4'hF: cls = OP_MISC_F;
			default: cls = OP_OTHER;
		endcase
	end

	chip8_alu u_alu (.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .flag(alu_flag));
	chip8_bcd u_bcd (.value(regs.rd_data1), .hundreds(bcd_h), .tens(bcd_t), .ones(bcd_o));

	always_comb begin
		// Defaults retire as a plain PC+2 with no writes
		regs.rd_idx1 = x_idx;
		regs.rd_idx2 = y_idx;
		regs.we1 = 1'b0;
		regs.wr_idx1 = x_idx;
		regs.wr_data1 = alu_result[7:0];
		regs.we2 = 1'b0;
		regs.wr_idx2 = VF_IDX;
		regs.wr_data2 = {7'h0, alu_flag};
		regs.i_we = 1'b0;
		regs.i_wdata = alu_result;
		regs.pc_src = PC_NEXT;
		regs.pc_target = nnn;
		alu_op = ALU_NOP;
		alu_a = {8'h0, regs.rd_data1};
		alu_b = {8'h0, regs.rd_data2};
		last_stage = (stage == 5'd0);
		mem_wr = 1'b0;
		mem_wdata = regs.rd_data1;
		case (cls)
			OP_JP: regs.pc_src = PC_JUMP;
			OP_SE_IMM:
				if (regs.rd_data1 == kk)
					regs.pc_src = PC_SKIP;
			OP_SNE_IMM:
				if (regs.rd_data1 != kk)
					regs.pc_src = PC_SKIP;
			// Register skips need a zero low nibble
			OP_SE_REG:
				if (n_low == 4'h0 && regs.rd_data1 == regs.rd_data2)
					regs.pc_src = PC_SKIP;
			OP_SNE_REG:
				if (n_low == 4'h0 && regs.rd_data1 != regs.rd_data2)
					regs.pc_src = PC_SKIP;
			OP_LD_IMM: begin
				alu_b = {8'h0, kk};
				regs.we1 = commit;
			end
			// No flag for 7xkk
			OP_ADD_IMM: begin
				alu_op = ALU_ADD;
				alu_b = {8'h0, kk};
				regs.we1 = commit;
			end
			OP_ARITH: begin
				case (n_low)
					4'h0: regs.we1 = commit;
					4'h1: alu_op = ALU_OR;
					4'h2: alu_op = ALU_AND;
					4'h3: alu_op = ALU_XOR;
					4'h4: alu_op = ALU_ADD;
					4'h5: alu_op = ALU_SUB;
					4'h6: alu_op = ALU_SHR;
					4'h7: begin
						// SUBN, operands swapped
						alu_op = ALU_SUB;
						alu_a = {8'h0, regs.rd_data2};
						alu_b = {8'h0, regs.rd_data1};
					end
					4'hE: alu_op = ALU_SHL;
					default: alu_op = ALU_NOP;
				endcase
				if (n_low inside {[4'h1:4'h7], 4'hE})
					regs.we1 = commit;
				// Only arithmetic and shifts touch VF
				if (n_low inside {[4'h4:4'h7], 4'hE})
					regs.we2 = commit;
			end
			OP_LD_I: begin
				alu_b = {4'h0, nnn};
				regs.i_we = commit;
			end
			OP_JP_V0: begin
				regs.rd_idx1 = 4'h0;
				alu_op = ALU_ADD;
				alu_a = {4'h0, nnn};
				alu_b = {8'h0, regs.rd_data1};
				regs.pc_src = PC_JUMP;
				regs.pc_target = alu_result[11:0];
			end
			OP_MISC_F: begin
				case (kk)
					8'h1E: begin
						alu_op = ALU_ADD;
						alu_a = regs.i_rdata;
						alu_b = {8'h0, regs.rd_data1};
						regs.i_we = commit;
					end
					8'h29: begin
						regs.i_wdata = {12'h000, regs.rd_data1[3:0]} * FONT_STRIDE;
						regs.i_we = commit;
					end
					8'h33: begin
						// Hundreds, tens, ones at I, I+1, I+2
						last_stage = (stage == 5'd2);
						mem_wr = 1'b1;
						case (stage)
							5'd0: mem_wdata = bcd_h;
							5'd1: mem_wdata = bcd_t;
							default: mem_wdata = bcd_o;
						endcase
					end
					8'h55: begin
						// One register per stage, V0 first
						regs.rd_idx1 = stage[3:0];
						last_stage = (stage == {1'b0, x_idx});
						mem_wr = 1'b1;
					end
					default: mem_wr = 1'b0;
				endcase
			end
			default: regs.pc_src = PC_NEXT;
		endcase
		regs.pc_upd = commit;
	end

	assign mem_we = exec_active && mem_wr;
	assign mem_addr = regs.i_rdata[11:0] + addr_t'(stage);

	// Nothing reaches memory once the sequencer has left EXEC
	a_no_late_write: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		commit |=> !mem_we);

endmodule

`default_nettype wire

//--- hw/chip8_core.sv
//**********************************************************
// CHIP-8 execute core, one instruction per handshake
// No memory reads, display, stack, keys or timers
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module chip8_core import chip8_isa_pkg::*, chip8_uarch_pkg::*; #(
	parameter addr_t RESET_PC = 12'h200
) (
	input wire logic cpu_clk,
	input wire logic arst_n,
	input wire logic [INSTR_W-1:0] instruction,
	input wire logic instr_req,
	output logic instr_ack,
	output addr_t pc,
	output logic mem_we,
	output addr_t mem_addr,
	output byte_t mem_wdata
);

	// Sequencer to exec framing
	stage_t stage;
	logic exec_active;
	logic last_stage;

	chip8_regs_if regs_bus ();

	chip8_sequencer u_seq (
		.cpu_clk(cpu_clk),
		.arst_n(arst_n),
		.instr_req(instr_req),
		.last_stage(last_stage),
		.exec_active(exec_active),
		.stage(stage),
		.instr_ack(instr_ack)
	);

	chip8_exec u_exec (
		.cpu_clk(cpu_clk),
		.arst_n(arst_n),
		.instruction(instruction),
		.exec_active(exec_active),
		.stage(stage),
		.last_stage(last_stage),
		.regs(regs_bus.master),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

	// PC comes straight from the state registers
	chip8_state_regs #(
		.RESET_PC(RESET_PC)
	) u_state (
		.cpu_clk(cpu_clk),
		.arst_n(arst_n),
		.regs(regs_bus.slave),
		.pc(pc)
	);

endmodule

`default_nettype wire

//--- sim/chip8_model.svh
//**********************************************************
// Reference model of the kept CHIP-8 instructions
// Included inside the testbench module and shares its scope
//**********************************************************
`ifndef CHIP8_MODEL_SVH
`define CHIP8_MODEL_SVH

// Architectural state as the instruction rules define it
byte_t m_v [16];
logic [15:0] m_i;
addr_t m_pc;

// Expected memory writes, address in [19:8] and data in [7:0]
logic [19:0] exp_wr [$];

function automatic void model_reset(input addr_t start_pc);
	int k;
	for (k = 0; k < 16; k++)
		m_v[k] = '0;
	m_i = '0;
	m_pc = start_pc;
	exp_wr.delete();
endfunction

// 8xy_ group, the flag is written last so it beats a result aimed at VF
function automatic void model_arith(input reg_idx_t x, input byte_t vx, input byte_t vy,
	input logic [3:0] n);
	logic [8:0] sum;
	sum = {1'b0, vx} + {1'b0, vy};
	case (n)
		4'h0: m_v[x] = vy;
		4'h1: m_v[x] = vx | vy;
		4'h2: m_v[x] = vx & vy;
		4'h3: m_v[x] = vx ^ vy;
		4'h4: begin
			m_v[x] = sum[7:0];
			m_v[15] = {7'h0, sum[8]};
		end
		4'h5: begin
			m_v[x] = vx - vy;
			m_v[15] = {7'h0, vx >= vy};
		end
		4'h6: begin
			m_v[x] = vx >> 1;
			m_v[15] = {7'h0, vx[0]};
		end
		4'h7: begin
			m_v[x] = vy - vx;
			m_v[15] = {7'h0, vy >= vx};
		end
		4'hE: begin
			m_v[x] = vx << 1;
			m_v[15] = {7'h0, vx[7]};
		end
		default: m_v[x] = vx;
	endcase
endfunction

// Fx__ group, memory writes go out in ascending address order
function automatic void model_misc(input reg_idx_t x, input byte_t vx, input byte_t kk);
	int k;
	addr_t a;
	case (kk)
		8'h1E: m_i = m_i + {8'h0, vx};
		8'h29: m_i = {12'h000, vx[3:0]} * 16'd5;
		8'h33: begin
			a = m_i[11:0];
			exp_wr.push_back({a, vx / 8'd100});
			a = a + 12'd1;
			exp_wr.push_back({a, (vx / 8'd10) % 8'd10});
			a = a + 12'd1;
			exp_wr.push_back({a, vx % 8'd10});
		end
		8'h55: begin
			for (k = 0; k <= int'(x); k++) begin
				a = m_i[11:0] + 12'(k);
				exp_wr.push_back({a, m_v[k[3:0]]});
			end
		end
		default: m_i = m_i;
	endcase
endfunction

// One instruction, anything undefined just moves the PC on
function automatic void model_step(input logic [15:0] ins);
	reg_idx_t x;
	reg_idx_t y;
	byte_t kk;
	addr_t nnn;
	addr_t next_pc;
	x = ins[11:8];
	y = ins[7:4];
	kk = ins[7:0];
	nnn = ins[11:0];
	next_pc = m_pc + 12'd2;
	case (ins[15:12])
		4'h1: next_pc = nnn;
		4'h3: if (m_v[x] == kk) next_pc = m_pc + 12'd4;
		4'h4: if (m_v[x] != kk) next_pc = m_pc + 12'd4;
		4'h5: if (ins[3:0] == 4'h0 && m_v[x] == m_v[y]) next_pc = m_pc + 12'd4;
		4'h9: if (ins[3:0] == 4'h0 && m_v[x] != m_v[y]) next_pc = m_pc + 12'd4;
		4'h6: m_v[x] = kk;
		4'h7: m_v[x] = m_v[x] + kk;
		4'h8: model_arith(x, m_v[x], m_v[y], ins[3:0]);
		4'hA: m_i = {4'h0, nnn};
		4'hB: next_pc = nnn + {4'h0, m_v[0]};
		4'hF: model_misc(x, m_v[x], kk);
		default: next_pc = m_pc + 12'd2;
	endcase
	m_pc = next_pc;
endfunction

`endif

//--- sim/tb_chip8_core.sv
//**********************************************************
// Random instruction stream against a reference model
// PC checked per instruction, memory writes in order
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module tb_chip8_core import chip8_isa_pkg::*; ();

	localparam addr_t RESET_PC = 12'h240;
	localparam int NUM_INSTR = 500;
	// Longest instruction is Fx55 with 16 stages
	localparam int ACK_TIMEOUT = 40;

	logic cpu_clk = 1'b0;
	logic arst_n;
	logic [15:0] instruction;
	logic instr_req;
	logic instr_ack;
	addr_t pc;
	logic mem_we;
	addr_t mem_addr;
	byte_t mem_wdata;

	integer seed;
	int errors;
	int checks;
	logic timed_out;
	logic ack_seen;
	logic req_seen;
	int n;

	// Observed memory writes, same packing as the expected queue
	logic [19:0] got_wr [$];

	`include "chip8_model.svh"

	chip8_core #(
		.RESET_PC(RESET_PC)
	) i_dut (
		.cpu_clk(cpu_clk),
		.arst_n(arst_n),
		.instruction(instruction),
		.instr_req(instr_req),
		.instr_ack(instr_ack),
		.pc(pc),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

	always #50 cpu_clk = ~cpu_clk;

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
		end
	endtask

	// Mid-cycle sampling, outputs settle after the rising edge
	always @(negedge cpu_clk) begin
		if (arst_n) begin
			if (mem_we)
				got_wr.push_back({mem_addr, mem_wdata});
			// Four-phase rules, req as it stood half a cycle before ack moved
			if (instr_ack && !ack_seen)
				check_value(32'(req_seen), 32'd1, "instr_req before instr_ack rise");
			if (!instr_ack && ack_seen)
				check_value(32'(req_seen), 32'd0, "instr_req before instr_ack fall");
			ack_seen = instr_ack;
		end else begin
			ack_seen = 1'b0;
		end
		req_seen = instr_req;
	end

	// Biased toward kept classes, Fx33 and Fx55 get extra weight
	function automatic logic [15:0] pick_instr();
		logic [31:0] rnd;
		logic [15:0] ins;
		rnd = $random(seed);
		case (rnd[19:16])
			4'h0: ins = {4'h1, rnd[11:1], 1'b0};
			4'h1: ins = {4'h3, rnd[11:0]};
			4'h2: ins = {4'h4, rnd[11:0]};
			4'h3: ins = {rnd[20] ? 4'h5 : 4'h9, rnd[11:4], rnd[21] ? rnd[3:0] : 4'h0};
			4'h4, 4'h5: ins = {4'h6, rnd[11:0]};
			4'h6: ins = {4'h7, rnd[11:0]};
			4'h7, 4'h8, 4'h9: ins = {4'h8, rnd[11:0]};
			4'hA: ins = {4'hA, rnd[11:0]};
			// nnn takes the parity of V0 so the jump target stays even
			4'hB: ins = {4'hB, rnd[11:1], m_v[0][0]};
			4'hC: begin
				case (rnd[21:20])
					2'd0: ins = {4'hF, rnd[11:8], 8'h1E};
					2'd1: ins = {4'hF, rnd[11:8], 8'h29};
					2'd2: ins = {4'hF, rnd[11:8], 8'h33};
					default: ins = {4'hF, rnd[11:8], 8'h55};
				endcase
			end
			4'hD: ins = {4'hF, rnd[11:8], 8'h33};
			4'hE: ins = {4'hF, rnd[11:8], 8'h55};
			default: begin
				// Dropped classes, these retire as PC+2
				case (rnd[21:20])
					2'd0: ins = {4'h0, rnd[11:0]};
					2'd1: ins = {4'h2, rnd[11:0]};
					2'd2: ins = {4'hC, rnd[11:0]};
					default: ins = {4'hE, rnd[11:0]};
				endcase
			end
		endcase
		return ins;
	endfunction

	task automatic compare_writes(input logic [15:0] ins);
		int k;
		check_value(32'(got_wr.size()), 32'(exp_wr.size()),
			$sformatf("write count for %h", ins));
		for (k = 0; k < exp_wr.size() && k < got_wr.size(); k++) begin
			check_value(32'(got_wr[k][19:8]), 32'(exp_wr[k][19:8]),
				$sformatf("write %0d address for %h", k, ins));
			check_value(32'(got_wr[k][7:0]), 32'(exp_wr[k][7:0]),
				$sformatf("write %0d data for %h", k, ins));
		end
		got_wr.delete();
		exp_wr.delete();
	endtask

	// One full request/ack cycle, called a short delay after a rising edge
	task automatic run_instr(input logic [15:0] ins);
		int waited;
		int hold;
		model_step(ins);
		instruction = ins;
		instr_req = 1'b1;
		waited = 0;
		while (!instr_ack && waited < ACK_TIMEOUT) begin
			@(posedge cpu_clk);
			#1;
			waited++;
		end
		if (!instr_ack) begin
			$display("Timeout: instr_ack never rose for instruction %h", ins);
			errors++;
			timed_out = 1'b1;
		end else begin
			// PC commits on the same edge that raises ack
			check_value(32'(pc), 32'(m_pc), $sformatf("pc after %h", ins));
			// Back-pressure, the core must sit in DONE with no side effects
			hold = $unsigned($random(seed)) % 3;
			repeat (hold) begin
				@(posedge cpu_clk);
				#1;
			end
			instr_req = 1'b0;
			waited = 0;
			while (instr_ack && waited < ACK_TIMEOUT) begin
				@(posedge cpu_clk);
				#1;
				waited++;
			end
			if (instr_ack) begin
				$display("Timeout: instr_ack stayed high after instr_req fell for %h", ins);
				errors++;
				timed_out = 1'b1;
			end else begin
				check_value(32'(pc), 32'(m_pc), $sformatf("pc after release of %h", ins));
				compare_writes(ins);
			end
		end
	endtask

	initial begin
		seed = 5;
		errors = 0;
		checks = 0;
		timed_out = 1'b0;
		ack_seen = 1'b0;
		req_seen = 1'b0;
		arst_n = 1'b0;
		instr_req = 1'b0;
		instruction = '0;
		model_reset(RESET_PC);
		repeat (3) @(posedge cpu_clk);
		#1;
		arst_n = 1'b1;

		// Reset state
		check_value(32'(pc), 32'(RESET_PC), "pc after reset");
		check_value(32'(instr_ack), 32'd0, "instr_ack after reset");
		check_value(32'(mem_we), 32'd0, "mem_we after reset");

		for (n = 0; n < NUM_INSTR && !timed_out; n++)
			run_instr(pick_instr());

		// Idle tail, nothing may reach memory
		if (!timed_out) begin
			repeat (4) @(posedge cpu_clk);
			#1;
			check_value(32'(got_wr.size()), 32'd0, "writes while idle");
		end

		$display("Done: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+sim
hw/chip8_isa_pkg.sv
hw/chip8_uarch_pkg.sv
hw/chip8_regs_if.sv
hw/chip8_alu.sv
hw/chip8_bcd.sv
hw/chip8_state_regs.sv
hw/chip8_sequencer.sv
hw/chip8_exec.sv
hw/chip8_core.sv
sim/tb_chip8_core.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_chip8_core -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/Vtb_chip8_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1
